/* include/rsa_config.svh */
`ifndef RSA_CONFIG_SVH
`define RSA_CONFIG_SVH

// operand width in bits, must be a multiple of 8
`define RSA_BITWIDTH 256

// peripheral register byte addresses on the 5-bit bus
`define RSA_RX_ADDR     5'd0
`define RSA_TX_ADDR     5'd4
`define RSA_STATUS_ADDR 5'd8

// status register flags
`define RSA_TX_OK_BIT 6 // transmit register can take a byte
`define RSA_RX_OK_BIT 7 // receive register holds a byte

`endif

/* design/rsa_io_pkg.sv */
`default_nettype none

package rsa_io_pkg;

    // bus side sequencing of the wrapper
    typedef enum logic [2:0] {
        S_GET_KEY_N, // shift in modulus
        S_GET_KEY_D, // shift in private exponent
        S_GET_DATA,  // shift in one ciphertext
        S_REQ_CALC,  // single start pulse to the core
        S_WAIT_CALC,
        S_SEND_DATA  // plaintext out, top byte dropped
    } wrapper_state_t;

endpackage

`default_nettype wire

/* design/rsa_core_pkg.sv */
`default_nettype none

package rsa_core_pkg;

    // modular exponentiation controller
    typedef enum logic [2:0] {
        CORE_IDLE,
        CORE_PREP,   // base * 2^bitwidth mod n
        CORE_MULT,   // result * power
        CORE_SQUARE, // power * power
        CORE_STEP,   // pick next exponent bit
        CORE_DONE
    } core_state_t;

    typedef enum logic [1:0] {MONT_IDLE, MONT_ITER, MONT_SUB} mont_state_t;

endpackage

`default_nettype wire

/* design/rsa_mont.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_mont #(
    parameter int bitwidth = `RSA_BITWIDTH
) (
    input  wire logic                avm_clk,
    input  wire logic                avm_rst,
    input  wire logic                start,
    input  wire logic [bitwidth-1:0] a,
    input  wire logic [bitwidth-1:0] b,
    input  wire logic [bitwidth-1:0] modulus,
    output logic [bitwidth-1:0]      product,
    output logic                     done
);

    import rsa_core_pkg::*;

    localparam int CNT_W = $clog2(bitwidth);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(bitwidth - 1);

    mont_state_t state_r;
    logic [CNT_W-1:0] cnt_r;
    logic [bitwidth-1:0] a_r;   // shifted right, lsb is the current bit
    logic [bitwidth+1:0] acc_r; // stays below 2n

    logic [bitwidth+1:0] sum_b;
    logic [bitwidth+1:0] sum_n;
    logic [bitwidth+1:0] diff;

    assign sum_b = acc_r + (a_r[0] ? {2'b00, b} : '0);
    assign sum_n = sum_b + (sum_b[0] ? {2'b00, modulus} : '0); // make it even
    assign diff  = acc_r - {2'b00, modulus};

    assign product = diff[bitwidth+1] ? acc_r[bitwidth-1:0] : diff[bitwidth-1:0];
    assign done    = (state_r == MONT_SUB);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r <= MONT_IDLE;
            cnt_r   <= '0;
        end else begin
            case (state_r)
                MONT_IDLE: begin
                    cnt_r <= '0;
                    if (start) state_r <= MONT_ITER;
                end
                MONT_ITER: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == LAST_BIT) state_r <= MONT_SUB;
                end
                default: state_r <= MONT_IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state_r == MONT_IDLE && start) begin
            a_r   <= a;
            acc_r <= '0;
        end else if (state_r == MONT_ITER) begin
            a_r   <= a_r >> 1;
            acc_r <= sum_n >> 1;
        end
    end

endmodule

`default_nettype wire

/* design/rsa_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_core #(
    parameter int bitwidth = `RSA_BITWIDTH
) (
    input  wire logic                avm_clk,
    input  wire logic                avm_rst,
    input  wire logic                start,
    input  wire logic [bitwidth-1:0] base,
    input  wire logic [bitwidth-1:0] exponent,
    input  wire logic [bitwidth-1:0] modulus,
    output logic [bitwidth-1:0]      result,
    output logic                     finished
);

    import rsa_core_pkg::*;

    localparam int CNT_W = $clog2(bitwidth + 1);
    localparam logic [CNT_W-1:0] LAST_PREP = CNT_W'(bitwidth - 1);
    localparam logic [CNT_W-1:0] ALL_BITS  = CNT_W'(bitwidth);

    core_state_t state_r;
    logic [CNT_W-1:0] cnt_r;
    logic mont_start_r;

    logic [bitwidth-1:0] power_r;  // base^(2^i), montgomery form
    logic [bitwidth-1:0] result_r; // plain form, starts at 1
    logic [bitwidth-1:0] exp_r;    // exponent, consumed lsb first

    logic [bitwidth:0] dbl;
    logic [bitwidth:0] dbl_sub;
    logic [bitwidth-1:0] prep_next;

    logic [bitwidth-1:0] mont_a;
    logic [bitwidth-1:0] mont_product;
    logic mont_done;

    // one doubling step of the domain conversion
    assign dbl       = {power_r, 1'b0};
    assign dbl_sub   = dbl - {1'b0, modulus};
    assign prep_next = (dbl >= {1'b0, modulus}) ? dbl_sub[bitwidth-1:0] : dbl[bitwidth-1:0];

    assign mont_a   = (state_r == CORE_MULT) ? result_r : power_r;
    assign result   = result_r;
    assign finished = (state_r == CORE_DONE);

    rsa_mont #(
        .bitwidth(bitwidth)
    ) mont_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start_r),
        .a       (mont_a),
        .b       (power_r),
        .modulus (modulus),
        .product (mont_product),
        .done    (mont_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r      <= CORE_IDLE;
            cnt_r        <= '0;
            mont_start_r <= 1'b0;
        end else begin
            mont_start_r <= 1'b0;
            case (state_r)
                CORE_IDLE: begin
                    if (start) begin
                        cnt_r   <= '0;
                        state_r <= CORE_PREP;
                    end
                end
                CORE_PREP: begin
                    if (cnt_r == LAST_PREP) begin
                        cnt_r   <= '0; // reused as exponent bit index
                        state_r <= CORE_STEP;
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                CORE_STEP: begin
                    if (cnt_r == ALL_BITS) begin
                        state_r <= CORE_DONE;
                    end else begin
                        mont_start_r <= 1'b1;
                        state_r      <= exp_r[0] ? CORE_MULT : CORE_SQUARE;
                    end
                end
                CORE_MULT: begin
                    if (mont_done) begin
                        mont_start_r <= 1'b1;
                        state_r      <= CORE_SQUARE;
                    end
                end
                CORE_SQUARE: begin
                    if (mont_done) begin
                        cnt_r   <= cnt_r + 1'b1;
                        state_r <= CORE_STEP;
                    end
                end
                default: state_r <= CORE_IDLE; // also leaves CORE_DONE
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state_r)
            CORE_IDLE: begin
                if (start) begin
                    power_r  <= base;
                    result_r <= bitwidth'(1);
                    exp_r    <= exponent;
                end
            end
            CORE_PREP: power_r <= prep_next;
            CORE_MULT: begin
                if (mont_done) result_r <= mont_product;
            end
            CORE_SQUARE: begin
                if (mont_done) begin
                    power_r <= mont_product;
                    exp_r   <= exp_r >> 1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/rsa_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_wrapper #(
    parameter int bitwidth = `RSA_BITWIDTH
) (
    input  wire logic        avm_clk,
    input  wire logic        avm_rst,
    output logic [4:0]       avm_address,
    output logic             avm_read,
    input  wire logic [31:0] avm_readdata,
    output logic             avm_write,
    output logic [31:0]      avm_writedata,
    input  wire logic        avm_waitrequest
);

    import rsa_io_pkg::*;

    localparam int CNT_W = $clog2(bitwidth / 8);
    localparam logic [CNT_W-1:0] LAST_RX = CNT_W'(bitwidth / 8 - 1);
    localparam logic [CNT_W-1:0] LAST_TX = CNT_W'(bitwidth / 8 - 2); // top byte never sent

    wrapper_state_t state_r;
    logic [CNT_W-1:0] byte_cnt_r;
    logic [4:0] address_r;
    logic read_r;
    logic write_r;
    logic start_r;

    logic [bitwidth-1:0] n_r;      // modulus
    logic [bitwidth-1:0] d_r;      // private exponent
    logic [bitwidth-1:0] cipher_r;
    logic [bitwidth-1:0] plain_r;

    logic [bitwidth-1:0] core_result;
    logic core_finished;

    logic xfer_done;
    logic rx_byte;
    logic tx_byte;

    assign xfer_done = (read_r | write_r) & ~avm_waitrequest;
    assign rx_byte   = xfer_done & read_r & (address_r == `RSA_RX_ADDR);
    assign tx_byte   = xfer_done & write_r;

    assign avm_address   = address_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {24'd0, plain_r[bitwidth-9 -: 8]};

    rsa_core #(
        .bitwidth(bitwidth)
    ) core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start_r),
        .base     (cipher_r),
        .exponent (d_r),
        .modulus  (n_r),
        .result   (core_result),
        .finished (core_finished)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r    <= S_GET_KEY_N;
            byte_cnt_r <= '0;
            address_r  <= `RSA_STATUS_ADDR;
            read_r     <= 1'b0;
            write_r    <= 1'b0;
            start_r    <= 1'b0;
        end else begin
            start_r <= 1'b0;
            case (state_r)
                S_GET_KEY_N, S_GET_KEY_D, S_GET_DATA: begin
                    read_r <= 1'b1; // first poll after reset
                    if (xfer_done) begin
                        if (address_r == `RSA_STATUS_ADDR && avm_readdata[`RSA_RX_OK_BIT]) begin
                            address_r <= `RSA_RX_ADDR;
                        end else if (address_r == `RSA_RX_ADDR) begin
                            address_r <= `RSA_STATUS_ADDR; // back to polling
                            if (byte_cnt_r == LAST_RX) begin
                                byte_cnt_r <= '0;
                                if (state_r == S_GET_KEY_N)
                                    state_r <= S_GET_KEY_D;
                                else if (state_r == S_GET_KEY_D)
                                    state_r <= S_GET_DATA;
                                else
                                    state_r <= S_REQ_CALC;
                            end else begin
                                byte_cnt_r <= byte_cnt_r + 1'b1;
                            end
                        end
                    end
                end
                S_REQ_CALC: begin
                    start_r <= 1'b1;
                    state_r <= S_WAIT_CALC;
                end
                S_WAIT_CALC: begin
                    if (core_finished) state_r <= S_SEND_DATA;
                end
                S_SEND_DATA: begin
                    if (xfer_done) begin
                        if (address_r == `RSA_STATUS_ADDR && avm_readdata[`RSA_TX_OK_BIT]) begin
                            address_r <= `RSA_TX_ADDR;
                            read_r    <= 1'b0;
                            write_r   <= 1'b1;
                        end else if (address_r == `RSA_TX_ADDR) begin
                            address_r <= `RSA_STATUS_ADDR;
                            read_r    <= 1'b1;
                            write_r   <= 1'b0;
                            if (byte_cnt_r == LAST_TX) begin
                                byte_cnt_r <= '0;
                                state_r    <= S_GET_DATA; // same key, next ciphertext
                            end else begin
                                byte_cnt_r <= byte_cnt_r + 1'b1;
                            end
                        end
                    end
                end
                default: state_r <= S_GET_KEY_N;
            endcase
        end
    end

    // received bytes enter from the bottom, msb first on the wire
    always_ff @(posedge avm_clk) begin
        if (rx_byte) begin
            case (state_r)
                S_GET_KEY_N: n_r      <= {n_r[bitwidth-9:0], avm_readdata[7:0]};
                S_GET_KEY_D: d_r      <= {d_r[bitwidth-9:0], avm_readdata[7:0]};
                default:     cipher_r <= {cipher_r[bitwidth-9:0], avm_readdata[7:0]};
            endcase
        end
        if (state_r == S_WAIT_CALC && core_finished)
            plain_r <= core_result;
        else if (tx_byte)
            plain_r <= {plain_r[bitwidth-9:0], 8'd0}; // next byte into the send window
    end

endmodule

`default_nettype wire

/* bench/rsa_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_properties (
    input wire logic                      avm_clk,
    input wire logic                      avm_rst,
    input wire logic [4:0]                avm_address,
    input wire logic                      avm_read,
    input wire logic                      avm_write,
    input wire logic [31:0]               avm_writedata,
    input wire logic                      avm_waitrequest,
    input wire logic                      start,
    input wire rsa_io_pkg::wrapper_state_t state
);

    import rsa_io_pkg::*;

    no_read_with_write: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else $error("read and write high in the same cycle");

    // only the three peripheral registers exist
    legal_address: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_address == `RSA_RX_ADDR || avm_address == `RSA_TX_ADDR
            || avm_address == `RSA_STATUS_ADDR)
        else $error("address outside the register map");

    write_to_tx_only: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> avm_address == `RSA_TX_ADDR && state == S_SEND_DATA)
        else $error("write outside the transmit register or send state");

    held_request: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest
            |=> $stable(avm_address) && $stable(avm_read) && $stable(avm_write))
        else $error("request changed while waitrequest was high");

    held_writedata: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write && avm_waitrequest |=> $stable(avm_writedata))
        else $error("writedata changed while waitrequest was high");

    // core start is a single pulse out of request calc
    start_pulse: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> state == S_WAIT_CALC ##1 !start)
        else $error("start not a single cycle pulse");

endmodule

`default_nettype wire

/* bench/rsa_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_checker #(
    parameter int bitwidth = `RSA_BITWIDTH
) (
    input  wire logic        avm_clk,
    input  wire logic        avm_rst,
    input  wire logic [4:0]  avm_address,
    input  wire logic        avm_read,
    input  wire logic        avm_write,
    input  wire logic [31:0] avm_readdata,
    input  wire logic [31:0] avm_writedata,
    input  wire logic        avm_waitrequest,
    output int               msg_done,
    output int               msg_failed,
    output int               err_count,
    output int               rx_total,
    output int               tx_in_msg
);

    localparam int BYTES = bitwidth / 8;
    localparam int SEND_BYTES = BYTES - 1; // top byte never leaves the wrapper

    logic [bitwidth-1:0] shift_r;
    logic [bitwidth-1:0] mod_n;
    logic [bitwidth-1:0] exp_d;
    logic [bitwidth-1:0] expect_r;
    logic pending = 1'b0; // plaintext owed on the transmit register
    int block_sel = 0;    // 0 modulus, 1 exponent, 2 ciphertext
    int rx_in_block = 0;
    int tx_cnt = 0;
    int wrong = 0;
    int msg_index = 0;
    int done_cnt = 0;
    int fail_cnt = 0;
    int err_cnt = 0;
    int rx_cnt = 0;

    // reference modexp, plain square-and-multiply on double width
    function automatic logic [bitwidth-1:0] mod_pow(input logic [bitwidth-1:0] base,
                                                    input logic [bitwidth-1:0] exponent,
                                                    input logic [bitwidth-1:0] modulus);
        logic [2*bitwidth-1:0] acc;
        logic [2*bitwidth-1:0] sq;
        logic [2*bitwidth-1:0] m;
        int i;
        m   = {{bitwidth{1'b0}}, modulus};
        acc = 1;
        sq  = {{bitwidth{1'b0}}, base} % m;
        for (i = 0; i < bitwidth; i++) begin
            if (exponent[i])
                acc = (acc * sq) % m;
            sq = (sq * sq) % m;
        end
        return acc[bitwidth-1:0];
    endfunction

    always @(posedge avm_clk) begin
        logic [7:0] exp_byte;
        if (avm_rst) begin
            if (pending) begin
                $display("message %0d: interrupted by reset after %0d bytes, discarded",
                         msg_index, tx_cnt);
                msg_index++;
            end
            pending     = 1'b0;
            block_sel   = 0; // wrapper reloads the key
            rx_in_block = 0;
            tx_cnt      = 0;
            wrong       = 0;
        end else if (!avm_waitrequest) begin
            if (avm_read && avm_address == `RSA_RX_ADDR) begin
                rx_cnt++;
                shift_r = {shift_r[bitwidth-9:0], avm_readdata[7:0]};
                if (rx_in_block == BYTES - 1) begin
                    rx_in_block = 0;
                    if (block_sel == 0) begin
                        mod_n     = shift_r;
                        block_sel = 1;
                    end else if (block_sel == 1) begin
                        exp_d     = shift_r;
                        block_sel = 2;
                    end else begin
                        if (pending) begin
                            $display("error at %0t: ciphertext read before plaintext %0d was sent",
                                     $time, msg_index);
                            err_cnt++;
                        end
                        expect_r = mod_pow(shift_r, exp_d, mod_n);
                        pending  = 1'b1;
                        tx_cnt   = 0;
                        wrong    = 0;
                    end
                end else begin
                    rx_in_block++;
                end
            end
            if (avm_write && avm_address == `RSA_TX_ADDR) begin
                if (!pending) begin
                    $display("error at %0t: transmit write with no message pending", $time);
                    err_cnt++;
                end else begin
                    exp_byte = expect_r[8*(SEND_BYTES-1-tx_cnt) +: 8]; // msb first
                    if (avm_writedata[7:0] !== exp_byte) begin
                        $display("CHECK FAILED at %0t: message %0d byte %0d expected %02h got %02h",
                                 $time, msg_index, tx_cnt, exp_byte, avm_writedata[7:0]);
                        wrong++;
                        err_cnt++;
                    end
                    tx_cnt++;
                    if (tx_cnt == SEND_BYTES) begin
                        if (wrong == 0) begin
                            $display("message %0d: %0d bytes matched", msg_index, SEND_BYTES);
                        end else begin
                            $display("message %0d: %0d of %0d bytes wrong",
                                     msg_index, wrong, SEND_BYTES);
                            fail_cnt++;
                        end
                        done_cnt++;
                        msg_index++;
                        pending = 1'b0;
                        tx_cnt  = 0;
                    end
                end
            end
        end
        msg_done   <= done_cnt;
        msg_failed <= fail_cnt;
        err_count  <= err_cnt;
        rx_total   <= rx_cnt;
        tx_in_msg  <= tx_cnt;
    end

endmodule

`default_nettype wire

/* bench/rsa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rsa_config.svh"

module rsa_tb;

    localparam int BW = `RSA_BITWIDTH;
    localparam int BYTES = BW / 8;
    localparam int NUM_MSGS = 9; // interrupted one included
    localparam int CALC_CYCLES = (2 * BW + 1) * (BW + 2);
    localparam int POLL_MARGIN = 64; // worst cycles per byte with polling
    localparam int MAX_CYCLES = NUM_MSGS * CALC_CYCLES + NUM_MSGS * 4 * BYTES * POLL_MARGIN;
    localparam logic [31:0] SEED = 32'ha9a8c9ca;

    logic avm_clk;
    logic avm_rst;
    logic [4:0] avm_address;
    logic avm_read;
    logic avm_write;
    logic [31:0] avm_writedata;
    logic [31:0] avm_readdata = '0;
    logic avm_waitrequest = 1'b1;

    logic [31:0] data_rng = SEED;
    logic [31:0] bus_rng = ~SEED; // separate stream for the bus side
    logic [7:0] rx_queue[$];
    int pushed_total = 0;
    int tb_errors = 0;
    int cycle_count;
    int msg_done;
    int msg_failed;
    int chk_errors;
    int rx_total;
    int tx_in_msg;

    rsa_wrapper #(
        .bitwidth(BW)
    ) dut_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    rsa_checker #(
        .bitwidth(BW)
    ) checker_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_readdata    (avm_readdata),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .msg_done        (msg_done),
        .msg_failed      (msg_failed),
        .err_count       (chk_errors),
        .rx_total        (rx_total),
        .tx_in_msg       (tx_in_msg)
    );

    bind rsa_wrapper rsa_properties props_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start_r),
        .state           (state_r)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        avm_clk = 1'b0;
        forever #10 avm_clk = ~avm_clk;
    end

    // peripheral model answering only a request that is already held
    always @(posedge avm_clk) begin
        bus_rng = lcg_step(bus_rng);
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
        end else begin
            if (avm_read && !avm_waitrequest && avm_address == `RSA_RX_ADDR) begin
                if (rx_queue.size() == 0) begin
                    $display("error at %0t: receive register read while empty", $time);
                    tb_errors++;
                end else begin
                    void'(rx_queue.pop_front());
                end
            end
            if ((avm_read || avm_write) && avm_waitrequest && bus_rng[31]) begin
                avm_waitrequest <= 1'b0;
                avm_readdata    <= '0;
                if (avm_address == `RSA_STATUS_ADDR) begin
                    avm_readdata[`RSA_RX_OK_BIT] <= (rx_queue.size() != 0) && bus_rng[30];
                    avm_readdata[`RSA_TX_OK_BIT] <= bus_rng[29];
                end else if (avm_address == `RSA_RX_ADDR && rx_queue.size() != 0) begin
                    avm_readdata <= {24'd0, rx_queue[0]};
                end
            end else begin
                avm_waitrequest <= 1'b1;
            end
        end
    end

    task automatic random_operand(output logic [BW-1:0] value);
        int i;
        for (i = 0; i < BW / 32; i++) begin
            data_rng = lcg_step(data_rng);
            value[32*i +: 32] = data_rng;
        end
    endtask

    task automatic new_key(output logic [BW-1:0] n, output logic [BW-1:0] d);
        random_operand(n);
        n[BW-1] = 1'b1; // full width and odd
        n[0]    = 1'b1;
        random_operand(d);
    endtask

    task automatic random_cipher(output logic [BW-1:0] c);
        random_operand(c);
        c[BW-1] = 1'b0; // stays below n
    endtask

    task automatic push_operand(input logic [BW-1:0] value);
        int i;
        for (i = BYTES - 1; i >= 0; i--) begin
            rx_queue.push_back(value[8*i +: 8]);
            pushed_total++;
        end
    endtask

    task automatic load_key(input logic [BW-1:0] n, input logic [BW-1:0] d);
        push_operand(n);
        push_operand(d);
    endtask

    task automatic decrypt(input logic [BW-1:0] cipher);
        int target;
        target = msg_done + 1;
        push_operand(cipher);
        while (msg_done < target) @(posedge avm_clk);
    endtask

    task automatic apply_reset();
        @(posedge avm_clk);
        avm_rst <= 1'b1;
        repeat (3) @(posedge avm_clk);
        avm_rst <= 1'b0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge avm_clk);
            cycle_count++;
        end
        $display("timeout: no output received");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [BW-1:0] n_a;
        logic [BW-1:0] d_a;
        logic [BW-1:0] n_b;
        logic [BW-1:0] d_b;
        logic [BW-1:0] c;
        avm_rst = 1'b1;
        repeat (3) @(posedge avm_clk);
        avm_rst <= 1'b0;

        new_key(n_a, d_a);
        load_key(n_a, d_a);
        random_cipher(c);
        decrypt(c);
        repeat (3) begin // key stays loaded
            random_cipher(c);
            decrypt(c);
        end

        // edge values with a reset before each key load
        apply_reset();
        load_key(n_a, d_a);
        decrypt('0);
        decrypt(BW'(1));
        apply_reset();
        load_key(n_a, BW'(1));
        random_cipher(c);
        decrypt(c);

        random_cipher(c);
        push_operand(c);
        while (tx_in_msg < 10) @(posedge avm_clk);
        apply_reset(); // mid transmission
        new_key(n_b, d_b);
        load_key(n_b, d_b);
        random_cipher(c);
        decrypt(c);

        repeat (2) @(posedge avm_clk);
        if (rx_queue.size() != 0 || rx_total != pushed_total) begin
            $display("error: %0d bytes supplied but %0d read, %0d left in the queue",
                     pushed_total, rx_total, rx_queue.size());
            tb_errors++;
        end
        $display("summary: %0d messages checked, %0d failed, %0d check errors, %0d bench errors",
                 msg_done, msg_failed, chk_errors, tb_errors);
        if (msg_failed == 0 && chk_errors == 0 && tb_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rsa_wrapper.f */
+incdir+include
design/rsa_io_pkg.sv
design/rsa_core_pkg.sv
design/rsa_mont.sv
design/rsa_core.sv
design/rsa_wrapper.sv
bench/rsa_properties.sv
bench/rsa_checker.sv
bench/rsa_tb.sv

/* Bender.yml */
package:
  name: rsa_wrapper

export_include_dirs:
  - include

sources:
  - files:
      - design/rsa_io_pkg.sv
      - design/rsa_core_pkg.sv
      - design/rsa_mont.sv
      - design/rsa_core.sv
      - design/rsa_wrapper.sv
  - target: test
    files:
      - bench/rsa_properties.sv
      - bench/rsa_checker.sv
      - bench/rsa_tb.sv
